/* rtl/gnn_pkg.sv */
package gnn_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_EDGE_PE = 8;
    localparam int PE_TAG_W    = $clog2(NUM_EDGE_PE);

    localparam int NODE_ID_W = 8;     // also the info sram address width

    // a feature-vector address is {line, offset}
    localparam int FV_LINE_W   = 8;
    localparam int FV_OFFSET_W = 4;
    localparam int FV_ADDR_W   = FV_LINE_W + FV_OFFSET_W;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request from an edge pe, 11 bits
    typedef struct packed {
        logic [NODE_ID_W-1:0] node_id;
        logic [PE_TAG_W-1:0]  pe_tag;
    } node_req_t;

    // lookup result for the next stage, 15 bits
    typedef struct packed {
        logic [FV_ADDR_W-1:0] fv_addr;
        logic [PE_TAG_W-1:0]  pe_tag;
    } fv_entry_t;

endpackage

/* rtl/fifo_rd_if.sv */
interface fifo_rd_if #(
    parameter type payload_t = logic
);

    logic     rinc;     // pop strobe
    logic     valid;    // one-cycle pulse, the cycle after rinc
    payload_t data;
    logic     empty;

    modport fifo (
        input  rinc,
        output valid,
        output data,
        output empty
    );

    modport ctrl (
        output rinc,
        input  valid,
        input  data,
        input  empty
    );

endinterface

/* rtl/sram_if.sv */
interface sram_if;

    import gnn_pkg::*;

    logic [NODE_ID_W-1:0] a;      // read address
    logic                 cen;    // read enable, active low
    logic [FV_ADDR_W-1:0] d;      // flow-through read data
    logic                 wen;
    logic [NODE_ID_W-1:0] wa;     // load address
    logic [FV_ADDR_W-1:0] wd;

    modport ctrl (
        output a,
        output cen,
        input  d
    );

    modport mem (
        input  a,
        input  cen,
        output d,
        input  wen,
        input  wa,
        input  wd
    );

endinterface

/* rtl/sync_fifo.sv */
module sync_fifo #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    fifo_rd_if.fifo  rd
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   CNT_MAX  = (PTR_W + 1)'(DEPTH);
    localparam logic [PTR_W:0]   CNT_FULL = (PTR_W + 1)'(DEPTH - 1);

    payload_t buf_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_LAST) ? '0 : p + 1'b1;
    endfunction

    assign do_pop  = rd.rinc && (count != '0);
    assign do_push = push && (count != CNT_MAX);    // dropped only when truly out of slots

    // one slot held back for a lookup already in flight
    assign full     = (count >= CNT_FULL);
    assign rd.empty = (count == '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (do_push) begin
            buf_q[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (do_pop) begin
            rd.data <= buf_q[rd_ptr];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers, count, valid pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd.valid <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count    <= count + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
            rd.valid <= do_pop;     // head shows up one cycle after rinc
        end
    end

endmodule

/* rtl/fv_info_sram.sv */
module fv_info_sram (
    input  logic clk,
    input  logic reset,
    sram_if.mem  mem
);

    import gnn_pkg::*;

    localparam int ENTRIES = 1 << NODE_ID_W;

    logic [FV_ADDR_W-1:0] table_q [ENTRIES];    // node id -> fv address
    logic [FV_ADDR_W-1:0] d_hold;

    // load port
    always_ff @(posedge clk) begin
        if (mem.wen) begin
            table_q[mem.wa] <= mem.wd;
        end
    end

    // keeps the last word read while the macro is deselected
    always_ff @(posedge clk) begin
        if (reset) begin
            d_hold <= '0;
        end else if (!mem.cen) begin
            d_hold <= table_q[mem.a];
        end
    end

    // flow-through read
    assign mem.d = mem.cen ? d_hold : table_q[mem.a];

endmodule

/* rtl/fv_info_ctrl.sv */
module fv_info_ctrl (
    input  logic               clk,
    input  logic               reset,
    fifo_rd_if.ctrl            req,
    sram_if.ctrl               sram,
    input  logic               fv_full,
    output logic               fv_push,
    output gnn_pkg::fv_entry_t fv_push_data
);

    import gnn_pkg::*;

    typedef enum logic {
        IDLE  = 1'b0,
        FETCH = 1'b1
    } state_t;

    state_t               state;
    state_t               nx_state;
    logic [NODE_ID_W-1:0] nx_a;
    logic                 nx_cen;
    logic [PE_TAG_W-1:0]  tag_q;
    logic [PE_TAG_W-1:0]  nx_tag;
    logic                 nx_push;
    fv_entry_t            nx_push_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            sram.cen <= 1'b1;
            fv_push  <= 1'b0;
        end else begin
            state    <= nx_state;
            sram.cen <= nx_cen;
            fv_push  <= nx_push;
        end
    end

    always_ff @(posedge clk) begin
        sram.a       <= nx_a;
        tag_q        <= nx_tag;
        fv_push_data <= nx_push_data;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        nx_state     = state;
        nx_a         = sram.a;
        nx_cen       = 1'b1;
        nx_tag       = tag_q;
        nx_push      = 1'b0;
        nx_push_data = fv_push_data;
        req.rinc     = 1'b0;

        case (state)
            IDLE: begin
                if (req.valid) begin
                    // request landed, read its entry next cycle
                    nx_state = FETCH;
                    nx_a     = req.data.node_id;
                    nx_cen   = 1'b0;
                    nx_tag   = req.data.pe_tag;
                end else if (!req.empty && !fv_full) begin
                    req.rinc = 1'b1;
                end
            end

            FETCH: begin
                nx_push      = 1'b1;    // lands in the output fifo a cycle later
                nx_push_data = '{fv_addr: sram.d, pe_tag: tag_q};
                nx_state     = IDLE;
            end

            default: begin
                nx_state = IDLE;
            end
        endcase
    end

endmodule

/* rtl/fv_info_lookup.sv */
module fv_info_lookup #(
    parameter int REQ_DEPTH = 8,
    parameter int FV_DEPTH  = 4
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          req_push,
    input  logic [gnn_pkg::NODE_ID_W-1:0] req_node_id,
    input  logic [gnn_pkg::PE_TAG_W-1:0]  req_pe_tag,
    output logic                          req_full,

    input  logic                          load_en,
    input  logic [gnn_pkg::NODE_ID_W-1:0] load_addr,
    input  logic [gnn_pkg::FV_ADDR_W-1:0] load_data,

    input  logic                          fv_rinc,
    output logic                          fv_valid,
    output logic [gnn_pkg::FV_ADDR_W-1:0] fv_addr,
    output logic [gnn_pkg::PE_TAG_W-1:0]  fv_pe_tag,
    output logic                          fv_empty
);

    import gnn_pkg::*;

    node_req_t req_word;
    logic      fv_full;
    logic      fv_push;
    fv_entry_t fv_push_data;

    fifo_rd_if #(.payload_t(node_req_t)) req_rd ();
    fifo_rd_if #(.payload_t(fv_entry_t)) fv_rd ();
    sram_if                              sram_bus ();

    assign req_word = '{node_id: req_node_id, pe_tag: req_pe_tag};

    // load port goes straight to the sram write side
    assign sram_bus.wen = load_en;
    assign sram_bus.wa  = load_addr;
    assign sram_bus.wd  = load_data;

    // output fifo read side drained by the next stage
    assign fv_rd.rinc = fv_rinc;
    assign fv_valid   = fv_rd.valid;
    assign fv_addr    = fv_rd.data.fv_addr;
    assign fv_pe_tag  = fv_rd.data.pe_tag;
    assign fv_empty   = fv_rd.empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instances
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    sync_fifo #(
        .DEPTH     (REQ_DEPTH),
        .payload_t (node_req_t)
    ) req_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (req_push),
        .push_data (req_word),
        .full      (req_full),
        .rd        (req_rd)
    );

    fv_info_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req          (req_rd),
        .sram         (sram_bus),
        .fv_full      (fv_full),
        .fv_push      (fv_push),
        .fv_push_data (fv_push_data)
    );

    fv_info_sram u_sram (
        .clk   (clk),
        .reset (reset),
        .mem   (sram_bus)
    );

    sync_fifo #(
        .DEPTH     (FV_DEPTH),
        .payload_t (fv_entry_t)
    ) fv_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (fv_push),
        .push_data (fv_push_data),
        .full      (fv_full),
        .rd        (fv_rd)
    );

endmodule

/* include/fv_lookup_vectors.svh */
`ifndef FV_LOOKUP_VECTORS_SVH
`define FV_LOOKUP_VECTORS_SVH

typedef enum logic [1:0] {
    OP_LOAD  = 2'd0,    // arg written into the info sram at node
    OP_REQ   = 2'd1,    // node requested with pe tag arg, exp_addr expected back
    OP_PAUSE = 2'd2     // arg 1 stops draining, arg 0 resumes
} vec_op_e;

typedef struct packed {
    vec_op_e                       op;
    logic [gnn_pkg::NODE_ID_W-1:0] node;
    logic [gnn_pkg::FV_ADDR_W-1:0] arg;
    logic [gnn_pkg::FV_ADDR_W-1:0] exp_addr;
} vec_row_t;

localparam int NUM_VEC_ROWS = 32;

// a load row is applied once earlier lookups have drained
localparam vec_row_t VEC_TABLE [NUM_VEC_ROWS] = '{
    '{OP_LOAD,  8'd0,   12'h0a5, 12'h000},
    '{OP_LOAD,  8'd255, 12'hff3, 12'h000},
    '{OP_LOAD,  8'd1,   12'h123, 12'h000},
    '{OP_LOAD,  8'd17,  12'h450, 12'h000},
    '{OP_LOAD,  8'd42,  12'h7c1, 12'h000},
    '{OP_LOAD,  8'd128, 12'h808, 12'h000},
    '{OP_LOAD,  8'd200, 12'hc8f, 12'h000},
    '{OP_LOAD,  8'd99,  12'h3e2, 12'h000},
    // every pe tag once
    '{OP_REQ,   8'd0,   12'd0,   12'h0a5},
    '{OP_REQ,   8'd255, 12'd1,   12'hff3},
    '{OP_REQ,   8'd1,   12'd2,   12'h123},
    '{OP_REQ,   8'd17,  12'd3,   12'h450},
    '{OP_REQ,   8'd42,  12'd4,   12'h7c1},
    '{OP_REQ,   8'd128, 12'd5,   12'h808},
    '{OP_REQ,   8'd200, 12'd6,   12'hc8f},
    '{OP_REQ,   8'd99,  12'd7,   12'h3e2},
    // rewrite between two lookups of node 42
    '{OP_REQ,   8'd42,  12'd2,   12'h7c1},
    '{OP_LOAD,  8'd42,  12'h5d0, 12'h000},
    '{OP_REQ,   8'd42,  12'd5,   12'h5d0},
    // burst against a stalled drain, enough to raise req_full
    '{OP_PAUSE, 8'd0,   12'd1,   12'h000},
    '{OP_REQ,   8'd1,   12'd0,   12'h123},
    '{OP_REQ,   8'd17,  12'd1,   12'h450},
    '{OP_REQ,   8'd255, 12'd2,   12'hff3},
    '{OP_REQ,   8'd0,   12'd3,   12'h0a5},
    '{OP_REQ,   8'd42,  12'd4,   12'h5d0},
    '{OP_REQ,   8'd99,  12'd5,   12'h3e2},
    '{OP_REQ,   8'd128, 12'd6,   12'h808},
    '{OP_REQ,   8'd200, 12'd7,   12'hc8f},
    '{OP_REQ,   8'd1,   12'd1,   12'h123},
    '{OP_REQ,   8'd0,   12'd6,   12'h0a5},
    '{OP_REQ,   8'd255, 12'd4,   12'hff3},
    '{OP_PAUSE, 8'd0,   12'd0,   12'h000}
};

`endif

/* tests/tb_fv_info_lookup.sv */
module tb_fv_info_lookup;

    timeunit 1ns;
    timeprecision 1ps;

    import gnn_pkg::*;

    `include "fv_lookup_vectors.svh"

    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 12 * NUM_VEC_ROWS + 200;

    logic                 clk   = 1'b0;
    logic                 reset = 1'b1;
    logic                 req_push;
    logic [NODE_ID_W-1:0] req_node_id;
    logic [PE_TAG_W-1:0]  req_pe_tag;
    logic                 req_full;
    logic                 load_en;
    logic [NODE_ID_W-1:0] load_addr;
    logic [FV_ADDR_W-1:0] load_data;
    logic                 fv_rinc = 1'b0;
    logic                 fv_valid;
    logic [FV_ADDR_W-1:0] fv_addr;
    logic [PE_TAG_W-1:0]  fv_pe_tag;
    logic                 fv_empty;

    logic [FV_ADDR_W-1:0] model_mem [1 << NODE_ID_W];   // last value loaded per node
    fv_entry_t            exp_q [$];                    // results in request order
    logic                 drain_paused = 1'b0;
    logic                 valid_due    = 1'b0;
    logic                 saw_req_full;
    int                   drain_gap    = 0;
    int                   cycle_count  = 0;

    fv_info_lookup #(
        .REQ_DEPTH (8),
        .FV_DEPTH  (4)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .req_push    (req_push),
        .req_node_id (req_node_id),
        .req_pe_tag  (req_pe_tag),
        .req_full    (req_full),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .fv_rinc     (fv_rinc),
        .fv_valid    (fv_valid),
        .fv_addr     (fv_addr),
        .fv_pe_tag   (fv_pe_tag),
        .fv_empty    (fv_empty)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one table row per call, driven on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apply_row(input vec_row_t row);
        @(negedge clk);
        req_push = 1'b0;
        load_en  = 1'b0;
        case (row.op)
            OP_LOAD: begin
                while (exp_q.size() != 0) @(negedge clk);   // no lookup in flight
                load_en   = 1'b1;
                load_addr = row.node;
                load_data = row.arg;
                model_mem[row.node] = row.arg;
            end
            OP_REQ: begin
                while (req_full) begin
                    if (drain_paused) saw_req_full = 1'b1;
                    @(negedge clk);
                end
                assert (row.exp_addr === model_mem[row.node]) else begin
                    $display("table row for node %0d expects %h but the last load was %h",
                             row.node, row.exp_addr, model_mem[row.node]);
                    abort_run();
                end
                req_push    = 1'b1;
                req_node_id = row.node;
                req_pe_tag  = row.arg[PE_TAG_W-1:0];
                exp_q.push_back('{fv_addr: row.exp_addr, pe_tag: row.arg[PE_TAG_W-1:0]});
            end
            OP_PAUSE: begin
                if (row.arg[0]) begin
                    while (exp_q.size() != 0) @(negedge clk);   // stall from an empty pipe
                    saw_req_full = 1'b0;
                    drain_paused <= 1'b1;
                end else begin
                    if (req_full) saw_req_full = 1'b1;
                    assert (saw_req_full) else begin
                        $display("req_full never rose while draining was paused");
                        abort_run();
                    end
                    drain_paused <= 1'b0;
                end
            end
            default: begin
                $display("table row holds an unknown op kind");
                abort_run();
            end
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drain side with random gaps, checks every valid cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin : drain_loop
        fv_entry_t head;
        if (!reset) begin
            assert (fv_valid === valid_due) else begin
                $display("error at %0t ns: fv_valid %b, expected %b", $time, fv_valid, valid_due);
                abort_run();
            end
            if (fv_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("a result came out at %0t ns with no request outstanding", $time);
                    abort_run();
                end
                head = exp_q.pop_front();
                assert (fv_addr === head.fv_addr && fv_pe_tag === head.pe_tag) else begin
                    $display("error at %0t ns: got addr %h tag %0d, expected addr %h tag %0d",
                             $time, fv_addr, fv_pe_tag, head.fv_addr, head.pe_tag);
                    abort_run();
                end
            end
            if (!drain_paused && drain_gap == 0) begin
                fv_rinc   = 1'b1;           // also fires now and then on an empty fifo
                valid_due = !fv_empty;
                drain_gap = int'($urandom % 3);
            end else begin
                fv_rinc   = 1'b0;
                valid_due = 1'b0;
                if (drain_gap > 0) drain_gap--;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycle_count);
            abort_run();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(49));
        req_push     = 1'b0;
        req_node_id  = '0;
        req_pe_tag   = '0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        saw_req_full = 1'b0;

        repeat (RESET_CYCLES) @(negedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (fv_empty === 1'b1 && fv_valid === 1'b0 && req_full === 1'b0) else begin
            $display("error at %0t ns: after reset fv_empty %b fv_valid %b req_full %b",
                     $time, fv_empty, fv_valid, req_full);
            abort_run();
        end

        foreach (VEC_TABLE[i]) begin
            apply_row(VEC_TABLE[i]);
        end
        @(negedge clk);
        req_push = 1'b0;
        load_en  = 1'b0;

        while (exp_q.size() != 0) @(negedge clk);
        repeat (8) @(negedge clk);  // any stray result would trip the drain check

        if (fv_empty === 1'b1 && req_full === 1'b0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("fifos not empty at the end of the run");
            abort_run();
        end
    end

endmodule

/* fv_info_lookup.f */
+incdir+include
rtl/gnn_pkg.sv
rtl/fifo_rd_if.sv
rtl/sram_if.sv
rtl/sync_fifo.sv
rtl/fv_info_sram.sv
rtl/fv_info_ctrl.sv
rtl/fv_info_lookup.sv
tests/tb_fv_info_lookup.sv

/* Makefile */
SRCS := $(shell grep -v '^+' fv_info_lookup.f) include/fv_lookup_vectors.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_fv_info_lookup: fv_info_lookup.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f fv_info_lookup.f --top-module tb_fv_info_lookup -o Vtb_fv_info_lookup

run: obj_dir/Vtb_fv_info_lookup
	-obj_dir/Vtb_fv_info_lookup > sim.log 2>&1
	cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
